// File: files.f
+incdir+include
logic/rv_pkg.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/pc_unit.sv
logic/rv_core.sv
tests/core_checker.sv
tests/core_tb.sv

// File: tests/core_tb.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module core_tb;

	localparam int PROG_LEN = 200;
	localparam int PROG2_LEN = 30;
	localparam int CYCLE_LIMIT = 4 * (PROG_LEN + 1 + PROG2_LEN + 1) + 20;

	logic clk;
	logic reset;
	rv_pkg::word_t imem [1024];
	rv_pkg::word_t dmem [64]; // 256-byte data window
	rv_pkg::word_t imem_addr;
	rv_pkg::word_t imem_data;
	rv_pkg::dmem_req_t dmem_req;
	rv_pkg::word_t dmem_rdata;
	logic retire_valid;
	rv_pkg::retire_t retire;
	logic halted;
	rv_pkg::word_t halt_pc; // address of the word that should stop the core
	int value_errs;
	int other_errs;
	logic [31:0] lfsr;
	int cycles;

	rv_core DUT (.*);
	core_checker u_check (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	assign imem_data = imem[imem_addr[11:2]];
	assign dmem_rdata = dmem[dmem_req.addr[7:2]];

	always @(posedge clk) begin
		if (dmem_req.write) begin
			for (int b = 0; b < 4; b++) begin
				if (dmem_req.wmask[b]) begin
					dmem[dmem_req.addr[7:2]][b*8 +: 8] <= dmem_req.wdata[b*8 +: 8];
				end
			end
		end
	end

	// galois x^32+x^22+x^2+x+1 stepped once per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic gen_program(input int len, input logic bad_end);
		logic [31:0] rnd;
		logic [31:0] kind;
		logic [31:0] off;
		logic [31:0] tgt;
		logic [7:0] o;
		logic [2:0] st_f3;
		int steps;
		for (int i = 0; i < 1024; i++) begin
			imem[i] = '0;
		end
		for (int i = 0; i < len; i++) begin
			kind = take_bits(4);
			rnd = take_bits(32);
			steps = 1 + int'(take_bits(2));
			if (steps > len - i) begin
				steps = len - i; // never past the last word
			end
			off = steps * 4;
			tgt = (i + steps) * 4;
			st_f3 = (rnd[13:12] == 2'd3) ? 3'd2 : {1'b0, rnd[13:12]};
			o = rnd[31:24] & (8'hff << st_f3); // width-aligned
			case (kind)
				0: imem[i] = {rnd[31:12], rnd[11:7], `OP_LUI};
				1: imem[i] = {rnd[31:12], rnd[11:7], `OP_AUIPC};
				2: imem[i] = {1'b0, off[10:1], 1'b0, 8'b0, rnd[11:7], `OP_JAL};
				3: imem[i] = {tgt[11:0], 5'd0, 3'b000, rnd[11:7], `OP_JALR};
				4: imem[i] = {off[12], off[10:5], rnd[24:20], rnd[19:15],
					rnd[13], 1'b0, rnd[13] | rnd[12], off[4:1], off[11], `OP_BRANCH};
				5: imem[i] = {4'b0, rnd[25:20], 2'b00, 5'd0, 3'b010, rnd[11:7], `OP_LOAD};
				6: imem[i] = {4'b0, rnd[27:20], 5'd0, 3'b100, rnd[11:7], `OP_LOAD};
				7: imem[i] = {4'b0, o[7:5], rnd[24:20], 5'd0, st_f3, o[4:0], `OP_STORE};
				8: imem[i] = {7'b0, rnd[24:20], rnd[19:15], 3'b001, rnd[11:7], `OP_IMM};
				9: imem[i] = {7'b0, rnd[24:20], rnd[19:15], 2'b00, rnd[12], rnd[11:7], `OP_REG};
				default: imem[i] = {rnd[31:20], rnd[19:15], rnd[13], rnd[12], rnd[12],
					rnd[11:7], `OP_IMM}; // addi, sltiu, xori, andi
			endcase
		end
		imem[len] = bad_end ? 32'h4020_80b3 : 32'h0010_0073; // sub x1,x1,x2 or ebreak
	endtask

	task automatic run_program(input int len);
		halt_pc = len * 4;
		for (int i = 0; i < 64; i++) begin
			dmem[i] = '0;
		end
		reset <= 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		while (!halted) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk); // quiet window after halt
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("timeout: core did not halt within %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		cycles = 0;
		halt_pc = '0;
		lfsr = 32'hfd3ea062;
		gen_program(PROG_LEN, 1'b0);
		run_program(PROG_LEN);
		gen_program(PROG2_LEN, 1'b1);
		run_program(PROG2_LEN);
		$display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: tests/core_checker.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module core_checker (
	input logic clk,
	input logic reset,
	input rv_pkg::word_t imem_addr,
	input rv_pkg::word_t imem_data,
	input rv_pkg::dmem_req_t dmem_req,
	input logic retire_valid,
	input rv_pkg::retire_t retire,
	input logic halted,
	input rv_pkg::word_t halt_pc,
	output int value_errs,
	output int other_errs
);

	rv_pkg::word_t regs [32];
	logic [7:0] mem [256];
	rv_pkg::word_t mpc;
	logic done; // model has executed a halting word

	initial begin
		value_errs = 0;
		other_errs = 0;
	end

	task automatic compare(input string name, input rv_pkg::word_t exp, input rv_pkg::word_t act);
		if (exp !== act) begin
			value_errs++;
			$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic report_failure(input string what);
		other_errs++;
		$display("%0t %s", $time, what);
	endtask

	task automatic step(input rv_pkg::word_t w);
		rv_pkg::word_t a;
		rv_pkg::word_t b;
		rv_pkg::word_t i_imm;
		rv_pkg::word_t ea;
		rv_pkg::word_t res;
		rv_pkg::word_t npc;
		rv_pkg::word_t sdata;
		logic [3:0] mask;
		logic ok;
		logic wr;
		logic store;
		logic load;
		a = regs[w[19:15]];
		b = regs[w[24:20]];
		i_imm = {{20{w[31]}}, w[31:20]};
		npc = mpc + 4;
		ok = 1'b1;
		wr = 1'b1;
		store = 1'b0;
		res = '0;
		ea = a + i_imm;
		case (w[6:0])
			`OP_LUI: res = {w[31:12], 12'b0};
			`OP_AUIPC: res = mpc + {w[31:12], 12'b0};
			`OP_JAL: begin
				res = npc;
				npc = mpc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			`OP_JALR: begin
				ok = (w[14:12] == 3'b000);
				res = npc;
				npc = ea & ~32'h1;
			end
			`OP_BRANCH: begin
				wr = 1'b0;
				ok = (w[14:12] == 3'b000) || (w[14:12] == 3'b001) || (w[14:12] == 3'b101);
				if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b) ||
					(w[14:12] == 3'b101 && $signed(a) >= $signed(b))) begin
					npc = mpc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				end
			end
			`OP_LOAD: begin
				ok = (w[14:12] == 3'b010) || (w[14:12] == 3'b100);
				res = (w[14:12] == 3'b100) ? {24'b0, mem[ea[7:0]]} :
					{mem[ea[7:0] + 8'd3], mem[ea[7:0] + 8'd2], mem[ea[7:0] + 8'd1], mem[ea[7:0]]};
			end
			`OP_STORE: begin
				wr = 1'b0;
				ok = (w[14:12] <= 3'b010);
				store = ok;
				ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
				mask = (w[14:12] == 3'b000) ? 4'b0001 << ea[1:0] :
					(w[14:12] == 3'b001) ? 4'b0011 << ea[1:0] : 4'b1111;
				sdata = (w[14:12] == 3'b000) ? {4{b[7:0]}} :
					(w[14:12] == 3'b001) ? {2{b[15:0]}} : b; // lane-replicated
			end
			`OP_IMM: begin
				case (w[14:12])
					3'b000: res = a + i_imm;
					3'b001: ok = (w[31:25] == 7'b0);
					3'b011: res = {31'b0, a < i_imm};
					3'b100: res = a ^ i_imm;
					3'b111: res = a & i_imm;
					default: ok = 1'b0;
				endcase
				if (w[14:12] == 3'b001) begin
					res = a << w[24:20]; // slli
				end
			end
			`OP_REG: begin
				ok = (w[31:25] == 7'b0) && (w[14:12] <= 3'b001);
				res = (w[14:12] == 3'b001) ? a << b[4:0] : a + b;
			end
			`OP_SYSTEM: begin
				ok = (w == 32'h0010_0073);
				wr = 1'b0;
			end
			default: ok = 1'b0;
		endcase
		wr = wr && ok && (w[11:7] != 5'd0); // x0 never written
		load = ok && (w[6:0] == `OP_LOAD);
		compare("retire.illegal", rv_pkg::word_t'(!ok), rv_pkg::word_t'(retire.illegal));
		compare("retire.writes_rd", rv_pkg::word_t'(wr), rv_pkg::word_t'(retire.writes_rd));
		compare("dmem_req.write", rv_pkg::word_t'(store), rv_pkg::word_t'(dmem_req.write));
		compare("dmem_req.read", rv_pkg::word_t'(load), rv_pkg::word_t'(dmem_req.read));
		if (wr) begin
			compare("retire.rd", rv_pkg::word_t'(w[11:7]), rv_pkg::word_t'(retire.rd));
			compare("retire.wdata", res, retire.wdata);
			regs[w[11:7]] = res;
		end
		if (store) begin
			compare("dmem_req.addr", ea, dmem_req.addr);
			compare("dmem_req.wmask", rv_pkg::word_t'(mask), rv_pkg::word_t'(dmem_req.wmask));
			compare("dmem_req.wdata", sdata, dmem_req.wdata);
			for (int k = 0; k < 4; k++) begin
				if (mask[k]) begin
					mem[{ea[7:2], 2'(k)}] = sdata[k*8 +: 8];
				end
			end
		end
		if (!ok || w == 32'h0010_0073) begin
			done = 1'b1;
			compare("halting pc", halt_pc, mpc);
		end
		mpc = npc;
	endtask

	// retire record settles by mid-cycle
	always @(negedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] = '0;
			end
			for (int i = 0; i < 256; i++) begin
				mem[i] = '0;
			end
			mpc = `RESET_PC;
			done = 1'b0;
			if (retire_valid || dmem_req.write || dmem_req.read || halted) begin
				report_failure("retire, memory strobe or halted is high during reset");
			end
		end else if (done) begin
			if (!halted) begin
				report_failure("halted is low after the halting instruction retired");
			end
			if (retire_valid || dmem_req.write || dmem_req.read) begin
				report_failure("retire or memory strobe seen after the core halted");
			end
		end else if (!retire_valid) begin
			report_failure("core stopped retiring before any halting instruction");
		end else begin
			compare("imem_addr", mpc, imem_addr);
			compare("retire.pc", mpc, retire.pc);
			mpc = retire.pc; // follow the core after a mismatch
			step(imem_data);
		end
	end

endmodule

// File: logic/rv_core.sv
`timescale 1ns/10ps

module rv_core (
	input logic clk,
	input logic reset,
	output rv_pkg::word_t imem_addr,
	input rv_pkg::word_t imem_data,
	output rv_pkg::dmem_req_t dmem_req,
	input rv_pkg::word_t dmem_rdata,
	output logic retire_valid,
	output rv_pkg::retire_t retire,
	output logic halted
);

	rv_pkg::word_t pc;
	rv_pkg::run_state_t state;
	rv_pkg::decoded_t dec;
	rv_pkg::decoded_t dec_x; // decode as seen by execute
	rv_pkg::word_t src1;
	rv_pkg::word_t src2;
	rv_pkg::word_t val;
	rv_pkg::word_t target;
	logic taken;
	logic running;

	assign running = (state == rv_pkg::RUNNING) && !reset;

	pc_unit u_pc (
		.clk(clk),
		.reset(reset),
		.taken(taken),
		.target(target),
		.halt_req(dec.is_halt),
		.pc(pc),
		.state(state)
	);

	instr_decode u_dec (
		.instr(imem_data),
		.dec(dec)
	);

	// idle core issues no memory strobes
	always_comb begin
		dec_x = dec;
		dec_x.is_halt = dec.is_halt || !running;
	end

	reg_file u_rf (
		.clk(clk),
		.reset(reset),
		.rs1(dec.rs1),
		.rs2(dec.rs2),
		.rd(dec.rd),
		.wen(running && dec.writes_rd),
		.wdata(val),
		.src1(src1),
		.src2(src2)
	);

	exec_unit u_exu (
		.dec(dec_x),
		.src1(src1),
		.src2(src2),
		.pc(pc),
		.dmem_rdata(dmem_rdata),
		.val(val),
		.taken(taken),
		.target(target),
		.dmem_req(dmem_req)
	);

	assign imem_addr = pc;
	assign retire_valid = running;
	assign retire.pc = pc;
	assign retire.rd = dec.rd;
	assign retire.wdata = val;
	assign retire.writes_rd = dec.writes_rd;
	assign retire.illegal = dec.illegal;
	assign halted = (state == rv_pkg::HALTED) && !reset;

endmodule

// File: logic/pc_unit.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module pc_unit (
	input logic clk,
	input logic reset,
	input logic taken,
	input rv_pkg::word_t target,
	input logic halt_req,
	output rv_pkg::word_t pc,
	output rv_pkg::run_state_t state
);

	rv_pkg::word_t pc_next;

	assign pc_next = taken ? target : pc + rv_pkg::word_t'(4);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rv_pkg::RUNNING;
			pc <= `RESET_PC;
		end else begin
			case (state)
				rv_pkg::RUNNING: begin
					if (halt_req) begin
						state <= rv_pkg::HALTED; // pc stays on the halting word
					end else begin
						pc <= pc_next;
					end
				end
				rv_pkg::HALTED: begin
					state <= rv_pkg::HALTED; // only reset leaves
				end
				default: begin
					state <= rv_pkg::HALTED;
				end
			endcase
		end
	end

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module exec_unit (
	input rv_pkg::decoded_t dec,
	input rv_pkg::word_t src1,
	input rv_pkg::word_t src2,
	input rv_pkg::word_t pc,
	input rv_pkg::word_t dmem_rdata,
	output rv_pkg::word_t val,
	output logic taken,
	output rv_pkg::word_t target,
	output rv_pkg::dmem_req_t dmem_req
);

	rv_pkg::word_t addr;
	rv_pkg::word_t link;
	rv_pkg::word_t load_byte;

	assign addr = src1 + dec.imm;
	assign link = pc + rv_pkg::word_t'(4);
	assign load_byte = {{(`XLEN-8){1'b0}}, dmem_rdata[addr[1:0]*8 +: 8]}; // lane by addr[1:0]

	// result select
	always_comb begin
		case (dec.opcode)
			`OP_LUI: val = dec.imm;
			`OP_AUIPC: val = pc + dec.imm;
			`OP_JAL, `OP_JALR: val = link;
			`OP_LOAD: val = (dec.funct3 == 3'b100) ? load_byte : dmem_rdata;
			`OP_IMM: begin
				case (dec.funct3)
					3'b000: val = src1 + dec.imm;
					3'b001: val = src1 << dec.imm[4:0]; // slli
					3'b011: val = {{(`XLEN-1){1'b0}}, src1 < dec.imm}; // unsigned
					3'b100: val = src1 ^ dec.imm;
					3'b111: val = src1 & dec.imm;
					default: val = '0;
				endcase
			end
			`OP_REG: val = (dec.funct3 == 3'b001) ? (src1 << src2[4:0]) : (src1 + src2);
			default: val = '0;
		endcase
	end

	// control transfer
	always_comb begin
		taken = 1'b0;
		target = pc + dec.imm;
		case (dec.opcode)
			`OP_JAL: taken = 1'b1;
			`OP_JALR: begin
				taken = 1'b1;
				target = {addr[`XLEN-1:1], 1'b0};
			end
			`OP_BRANCH: begin
				case (dec.funct3)
					3'b000: taken = (src1 == src2);
					3'b001: taken = (src1 != src2);
					3'b101: taken = ($signed(src1) >= $signed(src2));
					default: taken = 1'b0;
				endcase
			end
			default: taken = 1'b0;
		endcase
	end

	// data memory request
	always_comb begin
		dmem_req.addr = addr;
		case (dec.funct3)
			3'b000: begin
				dmem_req.wdata = {4{src2[7:0]}};
				dmem_req.wmask = rv_pkg::wmask_t'(1) << addr[1:0];
			end
			3'b001: begin
				dmem_req.wdata = {2{src2[15:0]}};
				dmem_req.wmask = rv_pkg::wmask_t'(3) << {addr[1], 1'b0};
			end
			default: begin
				dmem_req.wdata = src2;
				dmem_req.wmask = '1;
			end
		endcase
		dmem_req.read = (dec.opcode == `OP_LOAD) && !dec.is_halt;
		dmem_req.write = (dec.opcode == `OP_STORE) && !dec.is_halt;
	end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module reg_file (
	input logic clk,
	input logic reset,
	input rv_pkg::reg_idx_t rs1,
	input rv_pkg::reg_idx_t rs2,
	input rv_pkg::reg_idx_t rd,
	input logic wen,
	input rv_pkg::word_t wdata,
	output rv_pkg::word_t src1,
	output rv_pkg::word_t src2
);

	rv_pkg::word_t regs [`NREGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	assign src1 = (rs1 == '0) ? '0 : regs[rs1]; // x0 hardwired
	assign src2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: logic/instr_decode.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module instr_decode (
	input rv_pkg::word_t instr,
	output rv_pkg::decoded_t dec
);

	rv_pkg::word_t imm_i;
	rv_pkg::word_t imm_s;
	rv_pkg::word_t imm_b;
	rv_pkg::word_t imm_u;
	rv_pkg::word_t imm_j;
	rv_pkg::word_t imm; // immediate of the current format
	logic legal;
	logic is_ebreak;
	logic has_rd; // class produces a result

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign is_ebreak = (instr == 32'h0010_0073);

	always_comb begin
		legal = 1'b0;
		has_rd = 1'b0;
		imm = '0;
		case (instr[6:0])
			`OP_LUI, `OP_AUIPC: begin
				legal = 1'b1;
				has_rd = 1'b1;
				imm = imm_u;
			end
			`OP_JAL: begin
				legal = 1'b1;
				has_rd = 1'b1;
				imm = imm_j;
			end
			`OP_JALR, `OP_LOAD: begin
				legal = (instr[6:0] == `OP_JALR) ? (instr[14:12] == 3'b000) :
					(instr[14:12] == 3'b010 || instr[14:12] == 3'b100); // lw, lbu
				has_rd = 1'b1;
				imm = imm_i;
			end
			`OP_BRANCH: begin
				legal = (instr[14:12] == 3'b000 || instr[14:12] == 3'b001 ||
					instr[14:12] == 3'b101); // beq, bne, bge
				imm = imm_b;
			end
			`OP_STORE: begin
				legal = (instr[14:12] <= 3'b010); // sb, sh, sw
				imm = imm_s;
			end
			`OP_IMM: begin
				case (instr[14:12])
					3'b000, 3'b011, 3'b100, 3'b111: legal = 1'b1;
					3'b001: legal = (instr[31:25] == 7'b0); // slli
					default: legal = 1'b0;
				endcase
				has_rd = 1'b1;
				imm = imm_i;
			end
			`OP_REG: begin
				legal = (instr[31:25] == 7'b0) && (instr[14:12] <= 3'b001); // add, sll
				has_rd = 1'b1;
			end
			`OP_SYSTEM: legal = is_ebreak;
			default: legal = 1'b0;
		endcase
	end

	assign dec.opcode = instr[6:0];
	assign dec.funct3 = instr[14:12];
	assign dec.funct7 = instr[31:25];
	assign dec.rs1 = instr[19:15];
	assign dec.rs2 = instr[24:20];
	assign dec.rd = instr[11:7];
	assign dec.imm = imm;
	assign dec.writes_rd = legal && has_rd && (instr[11:7] != '0);
	assign dec.is_halt = is_ebreak || !legal;
	assign dec.illegal = !legal;

endmodule

// File: logic/rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [$clog2(`NREGS)-1:0] reg_idx_t;
	typedef logic [`XLEN/8-1:0] wmask_t; // one bit per byte lane
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	typedef enum logic {
		RUNNING,
		HALTED
	} run_state_t;

	typedef struct packed {
		opcode_t opcode;
		funct3_t funct3;
		funct7_t funct7;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t imm;
		logic writes_rd;
		logic is_halt; // ebreak or unsupported
		logic illegal;
	} decoded_t;

	typedef struct packed {
		word_t addr;
		word_t wdata; // lane-replicated for sb/sh
		wmask_t wmask;
		logic read;
		logic write;
	} dmem_req_t;

	typedef struct packed {
		word_t pc;
		reg_idx_t rd;
		word_t wdata;
		logic writes_rd;
		logic illegal;
	} retire_t;

endpackage

// File: include/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// datapath and address width
`define XLEN 32

// architectural register count
`define NREGS 32

// first fetch address
`define RESET_PC 32'h0000_0000

// base opcodes, instr[6:0]
`define OP_LUI 7'b0110111
`define OP_AUIPC 7'b0010111
`define OP_JAL 7'b1101111
`define OP_JALR 7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD 7'b0000011
`define OP_STORE 7'b0100011
`define OP_IMM 7'b0010011
`define OP_REG 7'b0110011
`define OP_SYSTEM 7'b1110011

`endif
